// File: compile.f
+incdir+design
+incdir+tests
design/linear_pkg.sv
design/operand_join.sv
design/dot_lane.sv
design/bias_add_slice.sv
design/fixed_linear.sv
tests/tb_fixed_linear.sv

// File: run_sim.sh
#!/bin/sh
# Build the fixed_linear testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_fixed_linear -f compile.f

# The log decides the result, so a simulator stop still reaches the search
./obj_dir/Vtb_fixed_linear > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// File: tests/linear_vectors.svh
`ifndef LINEAR_VECTORS_SVH
`define LINEAR_VECTORS_SVH

// Per vector: 8 data elements, a 4x8 weight matrix with one row per output, 4 biases
// Expected raw output = sum(data * weight) + (bias << 3), 6 fraction bits

localparam int num_vectors = 8;

localparam logic signed [`LIN_DATA_WIDTH-1:0] vec_data [num_vectors][`LIN_IN_FEATURES] = '{
    '{1, 2, 3, 4, 5, 6, 7, 8},
    '{8, 8, 8, 8, 8, 8, 8, 8},
    '{-1, 2, -3, 4, -5, 6, -7, 8},
    '{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768},
    '{0, 0, 0, 0, 0, 0, 0, 0},
    '{3, -3, 3, -3, 3, -3, 3, -3},
    '{100, 200, 300, 400, -100, -200, -300, -400},
    '{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767}
};

localparam logic signed [`LIN_WEIGHT_WIDTH-1:0]
    vec_weight [num_vectors][`LIN_OUT_FEATURES][`LIN_IN_FEATURES] = '{
    '{'{1, 1, 1, 1, 1, 1, 1, 1}, '{1, 0, 0, 0, 0, 0, 0, 0},
      '{0, 0, 0, 0, 0, 0, 0, 2}, '{8, 8, 8, 8, 8, 8, 8, 8}},
    '{'{8, 16, 24, 32, 40, 48, 56, 64}, '{100, 100, 100, 100, 100, 100, 100, 100},
      '{1, 2, 3, 4, 5, 6, 7, 8}, '{1000, 0, 0, 0, 0, 0, 0, 1000}},
    '{'{1, 1, 1, 1, 1, 1, 1, 1}, '{-1, -1, -1, -1, -1, -1, -1, -1},
      '{1, -1, 1, -1, 1, -1, 1, -1}, '{-2, 0, 0, 0, 0, 0, 0, -2}},
    '{'{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768},
      '{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767},
      '{-32768, 0, 0, 0, 0, 0, 0, 0}, '{0, 0, 0, 0, 0, 0, 0, 0}},
    '{'{1, 2, 3, 4, 5, 6, 7, 8}, '{-1, -1, -1, -1, -1, -1, -1, -1},
      '{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767},
      '{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768}},
    '{'{1, 1, 1, 1, 1, 1, 1, 1}, '{1, -1, 1, -1, 1, -1, 1, -1},
      '{10, 20, 30, 40, 50, 60, 70, 80}, '{100, 0, 0, 0, 0, 0, 0, 0}},
    '{'{1, 1, 1, 1, 1, 1, 1, 1}, '{1, 1, 1, 1, 0, 0, 0, 0},
      '{2, 2, 2, 2, -2, -2, -2, -2}, '{-5, 0, 0, 0, 0, 0, 0, 5}},
    '{'{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767},
      '{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768},
      '{1, 0, 0, 0, 0, 0, 0, 0}, '{0, 0, 0, 0, 0, 0, 0, -1}}
};

localparam logic signed [`LIN_BIAS_WIDTH-1:0] vec_bias [num_vectors][`LIN_OUT_FEATURES] = '{
    '{1, 2, 3, 4}, '{10, 20, 30, 40}, '{-1, -2, -3, -4}, '{-32768, 32767, -32768, -32768},
    '{5, -7, 32767, -32768}, '{0, 1, -1, 100}, '{2, 2, 2, 2}, '{32767, 32767, 0, -1}
};

localparam logic signed [`LIN_OUT_WIDTH-1:0] vec_expect [num_vectors][`LIN_OUT_FEATURES] = '{
    '{44, 17, 40, 320},
    '{2384, 6560, 528, 16320},
    '{-4, -20, -60, -46},
    '{38'sd8589672448, -38'sd8589410312, 38'sd1073479680, -262144},
    '{40, -56, 262136, -262144},
    '{0, 32, -128, 1100},
    '{16, 1016, 4016, -2484},
    '{38'sd8589672448, -38'sd8589410312, 32767, -32775}
};

`endif

// File: tests/tb_fixed_linear.sv
`include "linear_consts.svh"

`default_nettype none

module tb_fixed_linear;

    `include "linear_vectors.svh"

    // Round 0 runs back to back, round 1 adds idle gaps and output stalls
    localparam int num_passes = 2;
    localparam int total_outputs = num_passes * num_vectors;
    localparam int timeout_cycles = num_passes * num_vectors * `LIN_IN_DEPTH * 4 + 50;

    logic clk;
    logic rst;
    logic [`LIN_DATA_WIDTH-1:0] data_in_0 [`LIN_IN_PAR-1:0];
    logic data_in_0_valid;
    logic data_in_0_ready;
    logic [`LIN_WEIGHT_WIDTH-1:0] weight [`LIN_OUT_FEATURES*`LIN_IN_PAR-1:0];
    logic weight_valid;
    logic weight_ready;
    logic [`LIN_BIAS_WIDTH-1:0] bias [`LIN_OUT_FEATURES-1:0];
    logic bias_valid;
    logic bias_ready;
    logic [`LIN_OUT_WIDTH-1:0] data_out_0 [`LIN_OUT_FEATURES-1:0];
    logic data_out_0_valid;
    logic data_out_0_ready;

    int cycle;
    int out_count;
    int pass_count;
    int fail_count;
    int error_count;
    int stall_left;
    int last_beat_cycle [num_vectors];
    logic stall_mode;
    logic test_bad;
    logic held_valid;
    logic held_same;
    logic [`LIN_OUT_WIDTH-1:0] held_out [`LIN_OUT_FEATURES];

    fixed_linear fixed_linear_i (
        .clk              (clk),
        .rst              (rst),
        .data_in_0        (data_in_0),
        .data_in_0_valid  (data_in_0_valid),
        .data_in_0_ready  (data_in_0_ready),
        .weight           (weight),
        .weight_valid     (weight_valid),
        .weight_ready     (weight_ready),
        .bias             (bias),
        .bias_valid       (bias_valid),
        .bias_ready       (bias_ready),
        .data_out_0       (data_out_0),
        .data_out_0_valid (data_out_0_valid),
        .data_out_0_ready (data_out_0_ready)
    );

    always #5 clk = ~clk;

    // Idle cycles before a beat, only in the stalled round
    function automatic int idle_cycles(input int round);
        if (round == 0 || ($urandom % 3) != 0) begin
            return 0;
        end
        return 1 + ($urandom % 2);
    endfunction

    task automatic drive_data(input int round);
        int gap;
        for (int v = 0; v < num_vectors; v++) begin
            for (int b = 0; b < `LIN_IN_DEPTH; b++) begin
                gap = idle_cycles(round);
                @(negedge clk);
                if (gap > 0) begin
                    data_in_0_valid = 1'b0;
                    repeat (gap) @(negedge clk);
                end
                for (int k = 0; k < `LIN_IN_PAR; k++) begin
                    data_in_0[k] = vec_data[v][b*`LIN_IN_PAR + k];
                end
                data_in_0_valid = 1'b1;
                do begin
                    @(posedge clk);
                end while (!data_in_0_ready);
                if (b == `LIN_IN_DEPTH - 1) begin
                    last_beat_cycle[v] = cycle;
                end
            end
        end
        @(negedge clk);
        data_in_0_valid = 1'b0;
    endtask

    task automatic drive_weight(input int round);
        int gap;
        for (int v = 0; v < num_vectors; v++) begin
            for (int b = 0; b < `LIN_IN_DEPTH; b++) begin
                gap = idle_cycles(round);
                @(negedge clk);
                if (gap > 0) begin
                    weight_valid = 1'b0;
                    repeat (gap) @(negedge clk);
                end
                // Lane-major slices, the matching two columns of each row
                for (int l = 0; l < `LIN_OUT_FEATURES; l++) begin
                    for (int k = 0; k < `LIN_IN_PAR; k++) begin
                        weight[l*`LIN_IN_PAR + k] = vec_weight[v][l][b*`LIN_IN_PAR + k];
                    end
                end
                weight_valid = 1'b1;
                do begin
                    @(posedge clk);
                end while (!weight_ready);
            end
        end
        @(negedge clk);
        weight_valid = 1'b0;
    endtask

    task automatic drive_bias(input int round);
        int gap;
        for (int v = 0; v < num_vectors; v++) begin
            gap = idle_cycles(round);
            @(negedge clk);
            if (gap > 0) begin
                bias_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            for (int l = 0; l < `LIN_OUT_FEATURES; l++) begin
                bias[l] = vec_bias[v][l];
            end
            bias_valid = 1'b1;
            do begin
                @(posedge clk);
            end while (!bias_ready);
        end
        @(negedge clk);
        bias_valid = 1'b0;
    endtask

    // Output ready, short random dips plus longer stalls in round 1
    always @(negedge clk) begin
        if (!stall_mode) begin
            data_out_0_ready = 1'b1;
        end else if (stall_left > 0) begin
            data_out_0_ready = 1'b0;
            stall_left--;
        end else if (($urandom % 8) == 0) begin
            stall_left = 2 + ($urandom % 4);
            data_out_0_ready = 1'b0;
        end else begin
            data_out_0_ready = ($urandom % 4) != 0;
        end
    end

    task automatic check_output();
        int v;
        int round;
        v = out_count % num_vectors;
        round = out_count / num_vectors;
        if (out_count >= total_outputs) begin
            $display("An output arrived after every vector had already come out");
            error_count++;
            return;
        end
        for (int l = 0; l < `LIN_OUT_FEATURES; l++) begin
            assert (data_out_0[l] === vec_expect[v][l]) else begin
                $display("Fail data_out_0[%0d] vector %0d expected %h actual %h",
                         l, v, vec_expect[v][l], data_out_0[l]);
                error_count++;
                test_bad = 1'b1;
            end
        end
        // Latency only holds without gaps or stalls
        if (round == 0) begin
            assert (cycle == last_beat_cycle[v] + 2) else begin
                $display("Vector %0d came out %0d cycles after its last beat instead of 2",
                         v, cycle - last_beat_cycle[v]);
                error_count++;
                test_bad = 1'b1;
            end
        end
        if (test_bad) begin
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("test %0d, round %0d vector %0d: %s", out_count, round, v,
                 test_bad ? "failed" : "ok");
        test_bad = 1'b0;
        out_count++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            assert ((data_in_0_valid && data_in_0_ready) == (weight_valid && weight_ready))
            else begin
                $display("Data and weight beats were taken on different edges, cycle %0d", cycle);
                error_count++;
                test_bad = 1'b1;
            end
            if (held_valid) begin
                held_same = data_out_0_valid;
                for (int l = 0; l < `LIN_OUT_FEATURES; l++) begin
                    if (data_out_0[l] !== held_out[l]) begin
                        held_same = 1'b0;
                    end
                end
                assert (held_same) else begin
                    $display("Output changed or dropped while stalled, cycle %0d", cycle);
                    error_count++;
                    test_bad = 1'b1;
                end
            end
            held_valid = data_out_0_valid && !data_out_0_ready;
            for (int l = 0; l < `LIN_OUT_FEATURES; l++) begin
                held_out[l] = data_out_0[l];
            end
            if (data_out_0_valid && data_out_0_ready) begin
                check_output();
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("Timeout, the outputs did not arrive within %0d cycles", timeout_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(23));
        clk = 1'b0;
        rst = 1'b1;
        cycle = 0;
        out_count = 0;
        pass_count = 0;
        fail_count = 0;
        error_count = 0;
        stall_left = 0;
        stall_mode = 1'b0;
        test_bad = 1'b0;
        held_valid = 1'b0;
        held_same = 1'b1;
        data_in_0_valid = 1'b0;
        weight_valid = 1'b0;
        bias_valid = 1'b0;
        data_out_0_ready = 1'b0;
        for (int k = 0; k < `LIN_IN_PAR; k++) begin
            data_in_0[k] = '0;
        end
        for (int k = 0; k < `LIN_OUT_FEATURES*`LIN_IN_PAR; k++) begin
            weight[k] = '0;
        end
        for (int l = 0; l < `LIN_OUT_FEATURES; l++) begin
            bias[l] = '0;
            held_out[l] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int r = 0; r < num_passes; r++) begin
            stall_mode = (r == 1);
            fork
                drive_data(r);
                drive_weight(r);
                drive_bias(r);
            join
            wait (out_count == (r + 1) * num_vectors);
        end
        // A few more cycles to catch any extra output
        repeat (4) @(posedge clk);

        $display("%0d tests: %0d passed, %0d failed, %0d check errors",
                 out_count, pass_count, fail_count, error_count);
        if (error_count == 0 && out_count == total_outputs) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/fixed_linear.sv
`include "linear_consts.svh"

`default_nettype none

module fixed_linear (
    input  logic clk,
    input  logic rst,

    input  logic [`LIN_DATA_WIDTH-1:0] data_in_0 [`LIN_IN_PAR-1:0],
    input  logic data_in_0_valid,
    output logic data_in_0_ready,

    // Pre-transposed, lane-major
    input  logic [`LIN_WEIGHT_WIDTH-1:0] weight [`LIN_OUT_FEATURES*`LIN_IN_PAR-1:0],
    input  logic weight_valid,
    output logic weight_ready,

    input  logic [`LIN_BIAS_WIDTH-1:0] bias [`LIN_OUT_FEATURES-1:0],
    input  logic bias_valid,
    output logic bias_ready,

    output logic [`LIN_OUT_WIDTH-1:0] data_out_0 [`LIN_OUT_FEATURES-1:0],
    output logic data_out_0_valid,
    input  logic data_out_0_ready
);

    // Join to lanes
    logic [`LIN_DATA_WIDTH-1:0] lane_x [`LIN_IN_PAR-1:0];
    logic [`LIN_WEIGHT_WIDTH-1:0] lane_w [`LIN_OUT_FEATURES-1:0][`LIN_IN_PAR-1:0];
    linear_pkg::beat_phase_t lane_phase;
    logic lane_valid;
    logic [`LIN_OUT_FEATURES-1:0] lane_ready;

    // Lanes to bias slice
    logic [`LIN_OUT_WIDTH-1:0] acc_sum [`LIN_OUT_FEATURES-1:0];
    logic [`LIN_OUT_FEATURES-1:0] sum_valid;
    logic sum_ready;

    operand_join operand_join_i (
        .clk             (clk),
        .rst             (rst),
        .data_in_0       (data_in_0),
        .data_in_0_valid (data_in_0_valid),
        .data_in_0_ready (data_in_0_ready),
        .weight          (weight),
        .weight_valid    (weight_valid),
        .weight_ready    (weight_ready),
        .lane_x          (lane_x),
        .lane_w          (lane_w),
        .lane_phase      (lane_phase),
        .lane_valid      (lane_valid),
        .lane_ready      (lane_ready)
    );

    // One lane per output feature
    for (genvar i = 0; i < `LIN_OUT_FEATURES; i++) begin : g_lane
        dot_lane dot_lane_i (
            .clk        (clk),
            .rst        (rst),
            .lane_x     (lane_x),
            .lane_w     (lane_w[i]),
            .lane_phase (lane_phase),
            .lane_valid (lane_valid),
            .lane_ready (lane_ready[i]),
            .acc_sum    (acc_sum[i]),
            .sum_valid  (sum_valid[i]),
            .sum_ready  (sum_ready)
        );
    end

    bias_add_slice bias_add_slice_i (
        .clk              (clk),
        .rst              (rst),
        .acc_sum          (acc_sum),
        .sum_valid        (sum_valid),
        .sum_ready        (sum_ready),
        .bias             (bias),
        .bias_valid       (bias_valid),
        .bias_ready       (bias_ready),
        .data_out_0       (data_out_0),
        .data_out_0_valid (data_out_0_valid),
        .data_out_0_ready (data_out_0_ready)
    );

endmodule

`default_nettype wire

// File: design/bias_add_slice.sv
`include "linear_consts.svh"

`default_nettype none

module bias_add_slice (
    input  logic clk,
    input  logic rst,

    input  logic [`LIN_OUT_WIDTH-1:0] acc_sum [`LIN_OUT_FEATURES-1:0],
    input  logic [`LIN_OUT_FEATURES-1:0] sum_valid,
    output logic sum_ready,

    input  logic [`LIN_BIAS_WIDTH-1:0] bias [`LIN_OUT_FEATURES-1:0],
    input  logic bias_valid,
    output logic bias_ready,

    output logic [`LIN_OUT_WIDTH-1:0] data_out_0 [`LIN_OUT_FEATURES-1:0],
    output logic data_out_0_valid,
    input  logic data_out_0_ready
);

    localparam int OUT   = `LIN_OUT_FEATURES;
    localparam int OW    = `LIN_OUT_WIDTH;
    localparam int SHIFT = `LIN_OUT_FRAC - `LIN_BIAS_FRAC;

    linear_pkg::slot_state_t slot;
    logic slot_open;
    logic join_fire;
    logic signed [OW-1:0] bias_cast [OUT];
    logic [OUT*OW-1:0] out_flat;

    // Slot can take a new entry when empty or draining this cycle
    assign slot_open = (slot == linear_pkg::SLOT_EMPTY) || data_out_0_ready;

    // Lanes move in lockstep, lane 0 speaks for all of them
    assign sum_ready  = bias_valid && slot_open;
    assign bias_ready = sum_valid[0] && slot_open;
    assign join_fire  = sum_valid[0] && bias_valid && slot_open;

    assign data_out_0_valid = (slot == linear_pkg::SLOT_FULL);

    // Sign-extend, then move the bias fraction up to the output fraction
    always_comb begin
        for (int i = 0; i < OUT; i++) begin
            bias_cast[i] = $signed(bias[i]);
            bias_cast[i] = bias_cast[i] <<< SHIFT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= linear_pkg::SLOT_EMPTY;
        end else if (join_fire) begin
            slot <= linear_pkg::SLOT_FULL;
        end else if (data_out_0_ready) begin
            slot <= linear_pkg::SLOT_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (join_fire) begin
            for (int i = 0; i < OUT; i++) begin
                data_out_0[i] <= $signed(acc_sum[i]) + bias_cast[i];
            end
        end
    end

    // Packed copy of the output for the stall check
    always_comb begin
        for (int i = 0; i < OUT; i++) begin
            out_flat[i*OW +: OW] = data_out_0[i];
        end
    end

    lanes_in_lockstep: assert property (
        @(posedge clk) disable iff (rst)
        (&sum_valid) || !(|sum_valid)
    ) else $error("lane results are out of step");

    out_stable_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        data_out_0_valid && !data_out_0_ready |=> data_out_0_valid && $stable(out_flat)
    ) else $error("data_out_0 changed while stalled");

endmodule

`default_nettype wire

// File: design/dot_lane.sv
`include "linear_consts.svh"

`default_nettype none

module dot_lane (
    input  logic clk,
    input  logic rst,

    input  logic [`LIN_DATA_WIDTH-1:0] lane_x [`LIN_IN_PAR-1:0],
    input  logic [`LIN_WEIGHT_WIDTH-1:0] lane_w [`LIN_IN_PAR-1:0],
    input  linear_pkg::beat_phase_t lane_phase,
    input  logic lane_valid,
    output logic lane_ready,

    output logic [`LIN_OUT_WIDTH-1:0] acc_sum,
    output logic sum_valid,
    input  logic sum_ready
);

    localparam int PAR       = `LIN_IN_PAR;
    localparam int OW        = `LIN_OUT_WIDTH;
    localparam int PROD_W    = `LIN_DATA_WIDTH + `LIN_WEIGHT_WIDTH;
    localparam int PROD_FRAC = `LIN_DATA_FRAC + `LIN_WEIGHT_FRAC;
    // Product and output fractions line up for the default formats
    localparam int ALIGN     = `LIN_OUT_FRAC - PROD_FRAC;

    logic signed [PROD_W-1:0] prod [PAR];
    logic signed [OW-1:0] beat_sum;
    logic lane_fire;

    // A finished sum blocks new beats until the slice takes it
    assign lane_ready = !sum_valid;
    assign lane_fire  = lane_valid && lane_ready;

    always_comb begin
        for (int k = 0; k < PAR; k++) begin
            prod[k] = $signed(lane_x[k]) * $signed(lane_w[k]);
        end
    end

    // Sum of this beat's products, sign-extended to the output width
    always_comb begin
        beat_sum = '0;
        for (int k = 0; k < PAR; k++) begin
            beat_sum = beat_sum + (OW'(prod[k]) <<< ALIGN);
        end
    end

    always_ff @(posedge clk) begin
        if (lane_fire) begin
            if (lane_phase == linear_pkg::BEAT_FIRST) begin
                acc_sum <= beat_sum;
            end else begin
                acc_sum <= $signed(acc_sum) + beat_sum;
            end
        end
    end

    // Result is presented the cycle after the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else if (lane_fire && lane_phase == linear_pkg::BEAT_LAST) begin
            sum_valid <= 1'b1;
        end else if (sum_valid && sum_ready) begin
            sum_valid <= 1'b0;
        end
    end

    // The join must hold beats back while any lane is full
    no_beat_while_full: assert property (
        @(posedge clk) disable iff (rst)
        sum_valid |-> !lane_valid
    ) else $error("beat offered to a lane that still holds a result");

endmodule

`default_nettype wire

// File: design/operand_join.sv
`include "linear_consts.svh"

`default_nettype none

module operand_join (
    input  logic clk,
    input  logic rst,

    input  logic [`LIN_DATA_WIDTH-1:0] data_in_0 [`LIN_IN_PAR-1:0],
    input  logic data_in_0_valid,
    output logic data_in_0_ready,

    // Lane-major, LIN_IN_PAR elements per lane
    input  logic [`LIN_WEIGHT_WIDTH-1:0] weight [`LIN_OUT_FEATURES*`LIN_IN_PAR-1:0],
    input  logic weight_valid,
    output logic weight_ready,

    output logic [`LIN_DATA_WIDTH-1:0] lane_x [`LIN_IN_PAR-1:0],
    output logic [`LIN_WEIGHT_WIDTH-1:0] lane_w [`LIN_OUT_FEATURES-1:0][`LIN_IN_PAR-1:0],
    output linear_pkg::beat_phase_t lane_phase,
    output logic lane_valid,
    input  logic [`LIN_OUT_FEATURES-1:0] lane_ready
);

    localparam int PAR   = `LIN_IN_PAR;
    localparam int OUT   = `LIN_OUT_FEATURES;
    localparam int DEPTH = `LIN_IN_DEPTH;
    localparam int CNT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [CNT_W-1:0] beat_cnt;
    logic all_ready;
    logic beat_fire;

    // Lanes run in lockstep, a beat needs every one of them
    assign all_ready = &lane_ready;

    // Neither stream is consumed without the other
    assign data_in_0_ready = weight_valid && all_ready;
    assign weight_ready    = data_in_0_valid && all_ready;
    assign lane_valid      = data_in_0_valid && weight_valid && all_ready;
    assign beat_fire       = lane_valid;

    // Same data beat goes to every lane
    assign lane_x = data_in_0;

    // Each lane gets its own weight slice
    always_comb begin
        for (int l = 0; l < OUT; l++) begin
            for (int k = 0; k < PAR; k++) begin
                lane_w[l][k] = weight[l*PAR + k];
            end
        end
    end

    always_comb begin
        if (beat_cnt == '0) begin
            lane_phase = linear_pkg::BEAT_FIRST;
        end else if (beat_cnt == CNT_W'(DEPTH - 1)) begin
            lane_phase = linear_pkg::BEAT_LAST;
        end else begin
            lane_phase = linear_pkg::BEAT_MID;
        end
    end

    // Beat position, wraps after the last beat of a vector
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            if (beat_cnt == CNT_W'(DEPTH - 1)) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Each source holds its beat until the join takes it
    data_held_until_taken: assert property (
        @(posedge clk) disable iff (rst)
        data_in_0_valid && !data_in_0_ready |=> data_in_0_valid
    ) else $error("data_in_0_valid dropped before its beat was taken");

    weight_held_until_taken: assert property (
        @(posedge clk) disable iff (rst)
        weight_valid && !weight_ready |=> weight_valid
    ) else $error("weight_valid dropped before its beat was taken");

endmodule

`default_nettype wire

// File: design/linear_pkg.sv
`default_nettype none

package linear_pkg;

    // Where a beat sits inside one input vector
    // Lanes restart, continue or finish the accumulator on it
    typedef enum logic [1:0] {
        BEAT_FIRST = 2'd0,
        BEAT_MID   = 2'd1,
        BEAT_LAST  = 2'd2
    } beat_phase_t;

    // Occupancy of the one-entry output slot
    typedef enum logic {
        SLOT_EMPTY = 1'b0,
        SLOT_FULL  = 1'b1
    } slot_state_t;

endpackage

`default_nettype wire

// File: design/linear_consts.svh
`ifndef LINEAR_CONSTS_SVH
`define LINEAR_CONSTS_SVH

// Input vector shape
`define LIN_IN_FEATURES 8
`define LIN_IN_PAR 2
// Beats per vector
`define LIN_IN_DEPTH 4

// One dot-product lane per output feature
`define LIN_OUT_FEATURES 4

// Data format, signed
`define LIN_DATA_WIDTH 16
`define LIN_DATA_FRAC 3

// Weight format, signed, arrives pre-transposed
`define LIN_WEIGHT_WIDTH 16
`define LIN_WEIGHT_FRAC 3

// Bias format, signed
`define LIN_BIAS_WIDTH 16
`define LIN_BIAS_FRAC 3

// Output format
// 16 + 16 + clog2(8) + clog2(4) + 1 for the bias, so no overflow
`define LIN_OUT_WIDTH 38
`define LIN_OUT_FRAC 6

`endif
